//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := rv_core_tb
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    localparam int          num_random = 200;
    localparam logic [31:0] lfsr_seed  = 32'hb5575e78;

    logic                      clk;
    logic                      rst_n;
    logic                      instr_valid;
    logic [31:0]               instr;
    logic [reg_addr_width-1:0] dbg_addr;
    logic [xlen-1:0]           dbg_data;
    logic                      illegal;

    // Stimulus table
    logic [31:0]               tbl_instr[$];
    logic [reg_addr_width-1:0] tbl_rd[$];
    logic [xlen-1:0]           tbl_val[$];
    logic                      tbl_ill[$];

    // Issued last cycle, checked in this one
    logic                      pend_valid;
    logic [reg_addr_width-1:0] pend_rd;
    logic [xlen-1:0]           pend_val;
    logic                      pend_ill;

    logic [xlen-1:0] shadow [num_regs];  // Reference register file
    logic [31:0]     lfsr_state;
    logic            reset_ok;
    int              tests;
    int              checks;
    int              errors;
    int              test_errors;

    rv_core i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dbg_addr    (dbg_addr),
        .dbg_data    (dbg_data),
        .illegal     (illegal)
    );

    always #5 clk = ~clk;

    initial begin
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

    // ##########################################################
    // Encoders and reference model
    // ##########################################################

    function automatic logic [31:0] op_word(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] imm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, opc_op_imm};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, opc_lui};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [xlen-1:0] ref_alu(input logic [2:0] f3, input logic alt,
                                                input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];  // Only the low five bits shift
        case (f3)
            f3_add:  return alt ? a - b : a + b;
            f3_sll:  return a << sh;
            f3_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            f3_sltu: return (a < b) ? 32'd1 : 32'd0;
            f3_xor:  return a ^ b;
            f3_sr: begin
                if (alt) return $signed(a) >>> sh;
                else return a >> sh;
            end
            f3_or:   return a | b;
            default: return a & b;
        endcase
    endfunction

    // ##########################################################
    // Drive and check
    // ##########################################################

    task automatic check_readback(input logic [4:0] rd, input logic [xlen-1:0] exp_val,
                                  input logic exp_ill);
        checks += 2;
        assert (dbg_data === exp_val) else begin
            $display("error: time %0t, x%0d reads %h, expected %h", $time, rd, dbg_data,
                     exp_val);
            errors++;
            test_errors++;
        end
        assert (illegal === exp_ill) else begin
            $display("error: time %0t, illegal is %b, expected %b", $time, illegal, exp_ill);
            errors++;
            test_errors++;
        end
    endtask

    // Next instruction goes out while the previous one is read back
    task automatic issue(input logic valid, input logic [31:0] word, input logic [4:0] rd,
                         input logic [xlen-1:0] val, input logic ill);
        @(posedge clk);
        #1;
        instr_valid = valid;
        instr       = word;
        dbg_addr    = pend_rd;
        @(negedge clk);
        if (pend_valid) begin
            check_readback(pend_rd, pend_val, pend_ill);
        end
        pend_valid = valid;
        pend_rd    = rd;
        pend_val   = val;
        pend_ill   = ill;
    endtask

    task automatic flush();
        issue(1'b0, 32'h0, 5'd0, '0, 1'b0);
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (test_errors == 0) begin
            $display("test %0d %s: passed", tests, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", tests, name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic add_entry(input logic [31:0] word, input logic [4:0] rd,
                             input logic [xlen-1:0] val, input logic ill);
        tbl_instr.push_back(word);
        tbl_rd.push_back(rd);
        tbl_val.push_back(val);
        tbl_ill.push_back(ill);
    endtask

    task automatic run_table(input string name);
        for (int i = 0; i < tbl_instr.size(); i++) begin
            issue(1'b1, tbl_instr[i], tbl_rd[i], tbl_val[i], tbl_ill[i]);
        end
        flush();
        tbl_instr.delete();
        tbl_rd.delete();
        tbl_val.delete();
        tbl_ill.delete();
        finish_test(name);
    endtask

    task automatic wait_reset_release(output logic released);
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < 50) begin
            @(posedge clk);
            n++;
        end
        released = (rst_n === 1'b1);
    endtask

    // ##########################################################
    // Directed tables
    // ##########################################################

    task automatic directed_tests();
        @(negedge clk);
        checks++;
        assert (illegal === 1'b0) else begin
            $display("error: time %0t, illegal is %b after reset", $time, illegal);
            errors++;
            test_errors++;
        end
        finish_test("reset");

        add_entry(imm_word(12'd100, 5'd0, f3_add, 5'd1), 5'd1, 32'h0000_0064, 1'b0);
        add_entry(imm_word(12'hfff, 5'd0, f3_add, 5'd2), 5'd2, 32'hffff_ffff, 1'b0);
        add_entry(imm_word(12'h800, 5'd0, f3_add, 5'd3), 5'd3, 32'hffff_f800, 1'b0);
        add_entry(imm_word(12'h7ff, 5'd0, f3_add, 5'd4), 5'd4, 32'h0000_07ff, 1'b0);
        add_entry(lui_word(20'h80000, 5'd5), 5'd5, 32'h8000_0000, 1'b0);
        add_entry(lui_word(20'h12345, 5'd6), 5'd6, 32'h1234_5000, 1'b0);
        add_entry(imm_word(12'h678, 5'd6, f3_add, 5'd6), 5'd6, 32'h1234_5678, 1'b0);
        run_table("immediates and lui");

        // x7 = 36, so shifts by x7 move 4 places
        add_entry(imm_word(12'd36, 5'd0, f3_add, 5'd7), 5'd7, 32'h0000_0024, 1'b0);
        add_entry(op_word(f7_base, 5'd6, 5'd1, f3_add, 5'd10), 5'd10, 32'h1234_56dc, 1'b0);
        add_entry(op_word(f7_alt, 5'd6, 5'd1, f3_add, 5'd11), 5'd11, 32'hedcb_a9ec, 1'b0);
        add_entry(op_word(f7_base, 5'd6, 5'd2, f3_and, 5'd12), 5'd12, 32'h1234_5678, 1'b0);
        add_entry(op_word(f7_base, 5'd5, 5'd1, f3_or, 5'd13), 5'd13, 32'h8000_0064, 1'b0);
        add_entry(op_word(f7_base, 5'd6, 5'd2, f3_xor, 5'd14), 5'd14, 32'hedcb_a987, 1'b0);
        add_entry(op_word(f7_base, 5'd7, 5'd6, f3_sll, 5'd15), 5'd15, 32'h2345_6780, 1'b0);
        add_entry(op_word(f7_base, 5'd7, 5'd5, f3_sr, 5'd16), 5'd16, 32'h0800_0000, 1'b0);
        add_entry(op_word(f7_alt, 5'd7, 5'd5, f3_sr, 5'd17), 5'd17, 32'hf800_0000, 1'b0);
        add_entry(op_word(f7_base, 5'd1, 5'd2, f3_slt, 5'd18), 5'd18, 32'h0000_0001, 1'b0);
        add_entry(op_word(f7_base, 5'd1, 5'd2, f3_sltu, 5'd19), 5'd19, 32'h0000_0000, 1'b0);
        add_entry(op_word(f7_base, 5'd2, 5'd5, f3_slt, 5'd20), 5'd20, 32'h0000_0001, 1'b0);
        add_entry(op_word(f7_base, 5'd5, 5'd1, f3_sltu, 5'd21), 5'd21, 32'h0000_0001, 1'b0);
        add_entry(imm_word(12'hfff, 5'd1, f3_sltu, 5'd23), 5'd23, 32'h0000_0001, 1'b0);
        add_entry(imm_word(12'h41f, 5'd5, f3_sr, 5'd24), 5'd24, 32'hffff_ffff, 1'b0);
        add_entry(imm_word(12'hfff, 5'd6, f3_xor, 5'd27), 5'd27, 32'hedcb_a987, 1'b0);
        run_table("register operations");

        add_entry(imm_word(12'd123, 5'd1, f3_add, 5'd0), 5'd0, 32'h0000_0000, 1'b0);
        add_entry(lui_word(20'hfffff, 5'd0), 5'd0, 32'h0000_0000, 1'b0);
        add_entry(op_word(f7_base, 5'd6, 5'd0, f3_add, 5'd8), 5'd8, 32'h1234_5678, 1'b0);
        add_entry(imm_word(12'hffb, 5'd0, f3_add, 5'd8), 5'd8, 32'hffff_fffb, 1'b0);
        run_table("register x0");

        add_entry(imm_word(12'd1, 5'd0, f3_add, 5'd9), 5'd9, 32'h0000_0001, 1'b0);
        add_entry(op_word(f7_base, 5'd9, 5'd9, f3_add, 5'd9), 5'd9, 32'h0000_0002, 1'b0);
        add_entry(imm_word(12'd3, 5'd9, f3_sll, 5'd9), 5'd9, 32'h0000_0010, 1'b0);
        add_entry(op_word(f7_alt, 5'd1, 5'd9, f3_add, 5'd9), 5'd9, 32'hffff_ffac, 1'b0);
        add_entry(imm_word(12'h402, 5'd9, f3_sr, 5'd9), 5'd9, 32'hffff_ffeb, 1'b0);
        run_table("dependent instructions");

        // Destination must keep its old value
        add_entry({20'h0, 5'd10, 7'b1101111}, 5'd10, 32'h1234_56dc, 1'b1);
        add_entry(imm_word(12'd1, 5'd12, f3_add, 5'd12), 5'd12, 32'h1234_5679, 1'b0);
        add_entry(op_word(7'b0000001, 5'd1, 5'd1, f3_add, 5'd11), 5'd11, 32'hedcb_a9ec, 1'b1);
        add_entry(op_word(f7_alt, 5'd1, 5'd2, f3_xor, 5'd14), 5'd14, 32'hedcb_a987, 1'b1);
        add_entry(imm_word({f7_alt, 5'd1}, 5'd1, f3_sll, 5'd13), 5'd13, 32'h8000_0064, 1'b1);
        add_entry(imm_word(12'd1, 5'd12, f3_add, 5'd12), 5'd12, 32'h1234_567a, 1'b0);
        run_table("illegal encodings");
    endtask

    // ##########################################################
    // Random phase
    // ##########################################################

    task automatic preload_regs();
        logic [31:0]     u;
        logic [31:0]     lo;
        logic [xlen-1:0] upper;
        shadow[0] = '0;
        for (int r = 1; r < num_regs; r++) begin
            u     = rand_bits(20);
            lo    = rand_bits(12);
            upper = {u[19:0], 12'b0};
            issue(1'b1, lui_word(u[19:0], 5'(r)), 5'(r), upper, 1'b0);
            shadow[r] = upper + sext12(lo[11:0]);
            issue(1'b1, imm_word(lo[11:0], 5'(r), f3_add, 5'(r)), 5'(r), shadow[r], 1'b0);
        end
        flush();
        finish_test("register preload");
    endtask

    task automatic random_sequence();
        logic [31:0]     r;
        logic            use_imm;
        logic            alt;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [2:0]      f3;
        logic [11:0]     imm;
        logic [31:0]     word;
        logic [xlen-1:0] opb;
        for (int n = 0; n < num_random; n++) begin
            r       = rand_bits(1);
            use_imm = r[0];
            r       = rand_bits(5);
            rd      = r[4:0];
            r       = rand_bits(5);
            rs1     = r[4:0];
            r       = rand_bits(3);
            f3      = r[2:0];
            alt     = 1'b0;
            if ((f3 == f3_add && !use_imm) || f3 == f3_sr) begin
                r   = rand_bits(1);
                alt = r[0];
            end
            if (use_imm) begin
                r   = rand_bits(12);
                imm = r[11:0];
                if (f3 == f3_sll || f3 == f3_sr) begin
                    imm[11:5] = alt ? f7_alt : f7_base;  // funct7 of shift immediates
                end
                opb  = sext12(imm);
                word = imm_word(imm, rs1, f3, rd);
            end else begin
                r    = rand_bits(5);
                rs2  = r[4:0];
                opb  = shadow[rs2];
                word = op_word(alt ? f7_alt : f7_base, rs2, rs1, f3, rd);
            end
            if (rd != 5'd0) begin
                shadow[rd] = ref_alu(f3, alt, shadow[rs1], opb);
            end
            issue(1'b1, word, rd, shadow[rd], 1'b0);
        end
        flush();
        finish_test("random sequence");
    endtask

    // ##########################################################
    // Main sequence
    // ##########################################################

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        dbg_addr    = '0;
        pend_valid  = 1'b0;
        pend_rd     = '0;
        pend_val    = '0;
        pend_ill    = 1'b0;
        lfsr_state  = lfsr_seed;
        reset_ok    = 1'b0;
        tests       = 0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;

        wait_reset_release(reset_ok);
        if (reset_ok) begin
            directed_tests();
            preload_regs();
            random_sequence();

            $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
            if (errors == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
        end else begin
            $display("reset was not released within 50 cycles");
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
source/rv_isa_pkg.sv
source/rv_ctrl_pkg.sv
source/decode_if.sv
source/regfile.sv
source/decoder.sv
source/alu.sv
source/rv_core.sv
bench/rv_core_tb.sv

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire                        clk,
    input  wire rv_ctrl_pkg::alu_op_e  op,
    input  wire  [rv_isa_pkg::xlen-1:0] a,
    input  wire  [rv_isa_pkg::xlen-1:0] b,
    output logic [rv_isa_pkg::xlen-1:0] result
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic [$clog2(xlen)-1:0] shamt;
    logic                    lt_signed;
    logic                    lt_unsigned;

    assign shamt       = b[$clog2(xlen)-1:0];  // Upper bits ignored
    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_xor:    result = a ^ b;
            alu_sll:    result = a << shamt;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $signed(a) >>> shamt;
            alu_slt:    result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu:   result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

    // Decoder must never hand over an encoding outside the enum
    a_op_defined: assert property (
        @(posedge clk) op inside {alu_add, alu_sub, alu_and, alu_or, alu_xor,
                                  alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu,
                                  alu_pass_b}
    ) else $error("alu: undefined operation %0d", op);

endmodule

`default_nettype wire

//--- source/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if;
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic [reg_addr_width-1:0] rs1;
    logic [reg_addr_width-1:0] rs2;
    logic [reg_addr_width-1:0] rd;
    logic [xlen-1:0]           imm;      // Sign extended, or upper for LUI
    alu_op_e                   alu_op;
    opb_sel_e                  opb_sel;
    logic                      wr_en;

    // Decoder side
    modport producer (
        output rs1, rs2, rd, imm, alu_op, opb_sel, wr_en
    );

    // Datapath side
    modport consumer (
        input rs1, rs2, rd, imm, alu_op, opb_sel, wr_en
    );

endinterface

`default_nettype wire

//--- source/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  wire        clk,
    input  wire [31:0] instr,
    input  wire        instr_valid,
    decode_if.producer dec,
    output logic       illegal_now
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            alt;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic            legal;

    // Same funct3 table for OP and OP-IMM
    function automatic alu_op_e map_funct3(input logic [2:0] f3, input logic use_alt);
        case (f3)
            f3_add:  return use_alt ? alu_sub : alu_add;
            f3_sll:  return alu_sll;
            f3_slt:  return alu_slt;
            f3_sltu: return alu_sltu;
            f3_xor:  return alu_xor;
            f3_sr:   return use_alt ? alu_sra : alu_srl;
            f3_or:   return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // ##########################################################
    // Fields and immediates
    // ##########################################################

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign alt    = (funct7 == f7_alt);

    assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    assign dec.rs1 = (opcode == opc_lui) ? '0 : instr[19:15];
    assign dec.rs2 = instr[24:20];
    assign dec.rd  = instr[11:7];

    // ##########################################################
    // Operation select and legality
    // ##########################################################

    always_comb begin
        dec.alu_op  = alu_add;
        dec.opb_sel = opb_reg;
        dec.imm     = imm_i;
        legal       = 1'b0;
        case (opcode)
            opc_op: begin
                dec.alu_op = map_funct3(funct3, alt);
                // Alt form only for SUB and SRA
                legal = (funct7 == f7_base) ||
                        (alt && ((funct3 == f3_add) || (funct3 == f3_sr)));
            end
            opc_op_imm: begin
                dec.opb_sel = opb_imm;
                // imm[11:5] is funct7 only for shifts
                dec.alu_op  = map_funct3(funct3, alt && (funct3 == f3_sr));
                if (funct3 == f3_sll) begin
                    legal = (funct7 == f7_base);
                end else if (funct3 == f3_sr) begin
                    legal = (funct7 == f7_base) || alt;
                end else begin
                    legal = 1'b1;
                end
            end
            opc_lui: begin
                dec.alu_op  = alu_pass_b;
                dec.opb_sel = opb_imm;
                dec.imm     = imm_u;
                legal       = 1'b1;
            end
            default: begin
                legal = 1'b0;  // Unsupported opcode
            end
        endcase
    end

    assign dec.wr_en   = instr_valid && legal;
    assign illegal_now = instr_valid && !legal;

    // Unknown instruction bits would leave write enable and operands unknown
    a_instr_known: assert property (
        @(posedge clk) instr_valid |-> !$isunknown(instr)
    ) else $error("decoder: valid instruction with unknown bits");

endmodule

`default_nettype wire

//--- source/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire                                  clk,
    input  wire  [rv_isa_pkg::reg_addr_width-1:0] rd_addr1,
    input  wire  [rv_isa_pkg::reg_addr_width-1:0] rd_addr2,
    input  wire  [rv_isa_pkg::reg_addr_width-1:0] rd_addr3,
    input  wire                                  wr_en,
    input  wire  [rv_isa_pkg::reg_addr_width-1:0] wr_addr,
    input  wire  [rv_isa_pkg::xlen-1:0]           wr_data,
    output logic [rv_isa_pkg::xlen-1:0]           rd_data1,
    output logic [rv_isa_pkg::xlen-1:0]           rd_data2,
    output logic [rv_isa_pkg::xlen-1:0]           rd_data3
);
    import rv_isa_pkg::*;

    logic [xlen-1:0] regs [num_regs];

    // ##########################################################
    // Write port
    // ##########################################################

    always_ff @(posedge clk) begin
        if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // ##########################################################
    // Read ports, x0 is forced to zero here
    // ##########################################################

    assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];  // rs1
    assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];  // rs2
    assign rd_data3 = (rd_addr3 == '0) ? '0 : regs[rd_addr3];  // Debug

    // Unknown address would corrupt an arbitrary register
    a_wr_addr_known: assert property (
        @(posedge clk) wr_en |-> !$isunknown(wr_addr)
    ) else $error("regfile: write enable with unknown address");

endmodule

`default_nettype wire

//--- source/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   instr_valid,
    input  wire  [31:0]                           instr,
    input  wire  [rv_isa_pkg::reg_addr_width-1:0] dbg_addr,
    output logic [rv_isa_pkg::xlen-1:0]           dbg_data,
    output logic                                  illegal
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    decode_if dec ();

    logic            illegal_now;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] opb;
    logic [xlen-1:0] alu_result;

    // ##########################################################
    // Decode
    // ##########################################################

    decoder u_decoder (
        .clk         (clk),
        .instr       (instr),
        .instr_valid (instr_valid),
        .dec         (dec.producer),
        .illegal_now (illegal_now)
    );

    // ##########################################################
    // Register file, port 3 is the debug read
    // ##########################################################

    regfile u_regfile (
        .clk      (clk),
        .rd_addr1 (dec.rs1),
        .rd_addr2 (dec.rs2),
        .rd_addr3 (dbg_addr),
        .wr_en    (dec.wr_en),
        .wr_addr  (dec.rd),
        .wr_data  (alu_result),  // Written back at the closing edge
        .rd_data1 (rs1_data),
        .rd_data2 (rs2_data),
        .rd_data3 (dbg_data)
    );

    // ##########################################################
    // Execute
    // ##########################################################

    assign opb = (dec.opb_sel == opb_imm) ? dec.imm : rs2_data;

    alu u_alu (
        .clk    (clk),
        .op     (dec.alu_op),
        .a      (rs1_data),
        .b      (opb),
        .result (alu_result)
    );

    // One cycle pulse after a bad instruction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            illegal <= 1'b0;
        end else begin
            illegal <= illegal_now;
        end
    end

endmodule

`default_nettype wire

//--- source/rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

    // ##########################################################
    // ALU operations
    // ##########################################################

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_sll    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_slt    = 4'd8,
        alu_sltu   = 4'd9,
        alu_pass_b = 4'd10  // LUI only
    } alu_op_e;

    // ##########################################################
    // Operand B source
    // ##########################################################

    typedef enum logic {
        opb_reg = 1'b0,  // rs2 data
        opb_imm = 1'b1
    } opb_sel_e;

endpackage

`default_nettype wire

//--- source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // ##########################################################
    // Datapath sizes
    // ##########################################################

    localparam int xlen           = 32;
    localparam int reg_addr_width = 5;
    localparam int num_regs       = 32;

    // ##########################################################
    // Major opcodes, instr[6:0]
    // ##########################################################

    localparam logic [6:0] opc_op     = 7'b0110011;  // R-type
    localparam logic [6:0] opc_op_imm = 7'b0010011;  // I-type
    localparam logic [6:0] opc_lui    = 7'b0110111;  // U-type

    // ##########################################################
    // funct3, instr[14:12]
    // ##########################################################

    localparam logic [2:0] f3_add  = 3'b000;  // ADD, SUB, ADDI
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;  // SRL and SRA share it
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // ##########################################################
    // funct7, instr[31:25]
    // ##########################################################

    localparam logic [6:0] f7_base = 7'b0000000;
    // Selects SUB and the arithmetic right shifts
    localparam logic [6:0] f7_alt  = 7'b0100000;

endpackage

`default_nettype wire
